// File: Makefile
SIM := obj_dir/VrvCoreTb

.PHONY: all run check clean

all: $(SIM)

$(SIM): rvCore.f $(wildcard hw/*.sv) $(wildcard tests/*.sv) $(wildcard tests/*.svh)
	verilator --binary --timing --assert --top-module rvCoreTb -Mdir obj_dir -f rvCore.f

sim.log: $(SIM)
	./$(SIM) | tee sim.log

run: sim.log
	grep -q -F '*** PASSED ***' sim.log

check:
	grep -q -F '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

// File: hw/rvAlu.sv
module rvAlu (
  input  rvCorePkg::ctrlT ctrl,
  input  logic [31:0]     pc,
  input  logic [31:0]     imm,
  input  logic [31:0]     rs1Data,
  input  logic [31:0]     rs2Data,
  output logic [31:0]     result,
  output logic            branchTaken
);
  import rvCorePkg::*;

  logic [31:0] opA;
  logic [31:0] opB;
  logic [4:0]  shamt;
  logic        condMet;

  ////////////////////////////////////////////////////////////
  // operand muxes
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (ctrl.aSrc)
      aPc:     opA = pc;
      aZero:   opA = 32'd0; // lui passes the immediate straight through
      default: opA = rs1Data;
    endcase
    case (ctrl.bSrc)
      bImm:    opB = imm;
      bFour:   opB = 32'd4;
      default: opB = rs2Data;
    endcase
  end

  assign shamt = opB[4:0];

  always_comb begin
    case (ctrl.aluOp)
      aluAdd:  result = opA + opB;
      aluSub:  result = opA - opB;
      aluSll:  result = opA << shamt;
      aluSlt:  result = {31'b0, $signed(opA) < $signed(opB)};
      aluSltu: result = {31'b0, opA < opB};
      aluXor:  result = opA ^ opB;
      aluSrl:  result = opA >> shamt;
      aluSra:  result = $signed(opA) >>> shamt;
      aluOr:   result = opA | opB;
      aluAnd:  result = opA & opB;
      default: result = opA + opB;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // branch comparator
  ////////////////////////////////////////////////////////////
  // compares the raw register values and never the alu result
  always_comb begin
    case (ctrl.memFunct3)
      3'b000:  condMet = (rs1Data == rs2Data);                   // beq
      3'b001:  condMet = (rs1Data != rs2Data);                   // bne
      3'b100:  condMet = ($signed(rs1Data) < $signed(rs2Data));  // blt
      3'b101:  condMet = ($signed(rs1Data) >= $signed(rs2Data)); // bge
      3'b110:  condMet = (rs1Data < rs2Data);                    // bltu
      3'b111:  condMet = (rs1Data >= rs2Data);                   // bgeu
      default: condMet = 1'b0;
    endcase
  end

  assign branchTaken = ctrl.branch && condMet;

endmodule

// File: hw/rvCore.sv
module rvCore (
  input  logic               clk,
  input  logic               rst,
  input  logic [31:0]        inst,
  input  logic [31:0]        dmemRdata,
  output logic [31:0]        instAddr,
  output rvCorePkg::dmemReqT dmemReq,
  output rvCorePkg::commitT  commit,
  output logic               halted
);
  import rvCorePkg::*;

  ctrlT        ctrl;
  logic [31:0] pc, imm;
  logic [31:0] rs1Data, rs2Data;
  logic [31:0] aluResult, loadData, wbData;
  logic [4:0]  rs1, rs2, rd;
  logic        branchTaken;
  logic        regWe;

  ////////////////////////////////////////////////////////////
  // units
  ////////////////////////////////////////////////////////////
  rvFetch fetch_i (
    .clk, .rst,
    .jump(ctrl.jump), .branchTaken, .pcASrc(ctrl.pcASrc), .ebreak(ctrl.ebreak),
    .imm, .rs1Data,
    .pc, .halted
  );

  assign instAddr = pc;

  rvDecoder decoder_i (.inst, .ctrl, .imm, .rs1, .rs2, .rd);

  rvRegFile regFile_i (
    .clk, .rst,
    .we(regWe), .waddr(rd), .wdata(wbData),
    .raddr1(rs1), .raddr2(rs2),
    .rdata1(rs1Data), .rdata2(rs2Data)
  );

  rvAlu alu_i (.ctrl, .pc, .imm, .rs1Data, .rs2Data, .result(aluResult), .branchTaken);

  // the alu sum doubles as the load/store address
  rvLsu lsu_i (
    .ctrl, .addr(aluResult), .storeData(rs2Data), .halted,
    .dmemRdata, .dmemReq, .loadData
  );

  ////////////////////////////////////////////////////////////
  // writeback and commit
  ////////////////////////////////////////////////////////////
  assign wbData = ctrl.memRead ? loadData : aluResult;
  assign regWe  = ctrl.regWrite && !halted; // the register file drops writes to x0 itself

  always_comb begin
    commit.valid = regWe && (rd != 5'd0); // writes to x0 are not reported
    commit.pc    = pc;
    commit.rd    = rd;
    commit.data  = wbData;
  end

  // once parked on ebreak the fetch address must not move again
  haltFreezesPc: assert property (
    @(posedge clk) disable iff (rst) halted |=> (instAddr == $past(instAddr))
  ) else $error("instAddr moved from %h while halted", $past(instAddr));

endmodule

// File: hw/rvCorePkg.sv
package rvCorePkg;

  ////////////////////////////////////////////////////////////
  // opcodes
  ////////////////////////////////////////////////////////////
  localparam logic [6:0] opLoad   = 7'b000_0011;
  localparam logic [6:0] opStore  = 7'b010_0011;
  localparam logic [6:0] opBranch = 7'b110_0011;
  localparam logic [6:0] opJal    = 7'b110_1111;
  localparam logic [6:0] opJalr   = 7'b110_0111;
  localparam logic [6:0] opAluImm = 7'b001_0011;
  localparam logic [6:0] opAluReg = 7'b011_0011;
  localparam logic [6:0] opLui    = 7'b011_0111;
  localparam logic [6:0] opAuipc  = 7'b001_0111;
  localparam logic [6:0] opSystem = 7'b111_0011;

  localparam logic [31:0] ebreakWord  = 32'h0010_0073;
  localparam logic [31:0] resetVector = 32'h8000_0000; // first fetch address

  ////////////////////////////////////////////////////////////
  // instruction formats overlaid on one 32 bit word
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rTypeT;

  typedef struct packed {
    logic [11:0] imm11to0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } iTypeT;

  typedef struct packed {
    logic [6:0] imm11to5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm4to0;
    logic [6:0] opcode;
  } sTypeT;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10to5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4to1;
    logic       imm11;
    logic [6:0] opcode;
  } bTypeT;

  typedef struct packed {
    logic [19:0] imm31to12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } uTypeT;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10to1;
    logic       imm11;
    logic [7:0] imm19to12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } jTypeT;

  typedef union packed {
    rTypeT r;
    iTypeT i;
    sTypeT s;
    bTypeT b;
    uTypeT u;
    jTypeT j;
  } instU;

  ////////////////////////////////////////////////////////////
  // control and bus types
  ////////////////////////////////////////////////////////////
  typedef enum logic [1:0] {aRs1 = 2'd0, aPc = 2'd1, aZero = 2'd2} aSrcT;
  typedef enum logic [1:0] {bRs2 = 2'd0, bImm = 2'd1, bFour = 2'd2} bSrcT;

  typedef enum logic [3:0] {
    aluAdd, aluSub, aluSll, aluSlt, aluSltu,
    aluXor, aluSrl, aluSra, aluOr, aluAnd
  } aluOpT;

  typedef struct packed {
    logic       regWrite;
    aSrcT       aSrc;
    bSrcT       bSrc;
    aluOpT      aluOp;
    logic       pcASrc;    // 0 selects pc, 1 selects rs1 as jump base
    logic       jump;
    logic       branch;
    logic       memRead;
    logic       memWrite;
    logic [2:0] memFunct3; // raw funct3 that the branch comparator reads too
    logic       ebreak;
  } ctrlT;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        read;
  } dmemReqT;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [4:0]  rd;
    logic [31:0] data;
  } commitT;

endpackage

// File: hw/rvDecoder.sv
module rvDecoder (
  input  logic [31:0]     inst,
  output rvCorePkg::ctrlT ctrl,
  output logic [31:0]     imm,
  output logic [4:0]      rs1,
  output logic [4:0]      rs2,
  output logic [4:0]      rd
);
  import rvCorePkg::*;

  instU        fmt;
  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [31:0] immI, immS, immB, immU, immJ;
  logic        rType, iType, sType, bType, uType, jType;
  logic        isSystem;
  aluOpT       aluOp;

  assign fmt    = inst;
  assign opcode = fmt.r.opcode;
  assign funct3 = fmt.r.funct3;
  assign rs1    = fmt.r.rs1;
  assign rs2    = fmt.r.rs2;
  assign rd     = fmt.r.rd;

  ////////////////////////////////////////////////////////////
  // immediate generation
  ////////////////////////////////////////////////////////////
  assign immI = {{20{fmt.i.imm11to0[11]}}, fmt.i.imm11to0};
  assign immS = {{20{fmt.s.imm11to5[6]}}, fmt.s.imm11to5, fmt.s.imm4to0};
  assign immB = {{19{fmt.b.imm12}}, fmt.b.imm12, fmt.b.imm11, fmt.b.imm10to5,
                 fmt.b.imm4to1, 1'b0};
  assign immU = {fmt.u.imm31to12, 12'b0};
  assign immJ = {{11{fmt.j.imm20}}, fmt.j.imm20, fmt.j.imm19to12, fmt.j.imm11,
                 fmt.j.imm10to1, 1'b0};

  // anything outside these format groups retires as a no-op
  assign rType    = (opcode == opAluReg);
  assign iType    = (opcode == opLoad) || (opcode == opJalr) || (opcode == opAluImm);
  assign sType    = (opcode == opStore);
  assign bType    = (opcode == opBranch);
  assign uType    = (opcode == opLui) || (opcode == opAuipc);
  assign jType    = (opcode == opJal);
  assign isSystem = (opcode == opSystem); // ecall and csr ops land here too and do nothing

  assign imm = iType ? immI :
               sType ? immS :
               bType ? immB :
               uType ? immU :
               jType ? immJ : 32'b0;

  ////////////////////////////////////////////////////////////
  // alu operation from funct3 and funct7
  ////////////////////////////////////////////////////////////
  always_comb begin
    aluOp = aluAdd; // loads, stores, lui, auipc and jumps all add
    if (rType || opcode == opAluImm) begin
      case (funct3)
        3'b000: begin
          if (rType && fmt.r.funct7[5]) aluOp = aluSub; // addi has no subtract form
          else aluOp = aluAdd;
        end
        3'b001: aluOp = aluSll;
        3'b010: aluOp = aluSlt;
        3'b011: aluOp = aluSltu;
        3'b100: aluOp = aluXor;
        3'b101: begin
          if (fmt.r.funct7[5]) aluOp = aluSra; // imm[10] for srai sits in the same bit
          else aluOp = aluSrl;
        end
        3'b110: aluOp = aluOr;
        default: aluOp = aluAnd;
      endcase
    end
  end

  always_comb begin
    ctrl          = '0;
    ctrl.regWrite = rType || iType || uType || jType;
    ctrl.aluOp    = aluOp;

    if (opcode == opLui) ctrl.aSrc = aZero;
    else if (opcode == opAuipc || jType || opcode == opJalr) ctrl.aSrc = aPc;
    else ctrl.aSrc = aRs1;

    if (rType || bType) ctrl.bSrc = bRs2;
    else if (jType || opcode == opJalr) ctrl.bSrc = bFour; // link value is pc + 4
    else ctrl.bSrc = bImm;

    ctrl.pcASrc    = (opcode == opJalr);
    ctrl.jump      = jType || (opcode == opJalr);
    ctrl.branch    = bType;
    ctrl.memRead   = (opcode == opLoad);
    ctrl.memWrite  = sType;
    ctrl.memFunct3 = funct3;
    ctrl.ebreak    = isSystem && (inst == ebreakWord);

    assert (ctrl.aSrc != 2'd3 && ctrl.bSrc != 2'd3)
      else $error("decoder produced operand select 3 for inst %h", inst);
    assert (!(ctrl.memRead && ctrl.memWrite))
      else $error("decoder flagged both load and store for inst %h", inst);
  end

endmodule

// File: hw/rvFetch.sv
module rvFetch (
  input  logic        clk,
  input  logic        rst,
  input  logic        jump,
  input  logic        branchTaken,
  input  logic        pcASrc,
  input  logic        ebreak,
  input  logic [31:0] imm,
  input  logic [31:0] rs1Data,
  output logic [31:0] pc,
  output logic        halted
);
  import rvCorePkg::*;

  logic [31:0] base;
  logic [31:0] offset;
  logic [31:0] target;

  assign base   = pcASrc ? rs1Data : pc;                 // jalr jumps off rs1
  assign offset = (jump || branchTaken) ? imm : 32'd4;
  assign target = base + offset;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc     <= resetVector;
      halted <= 1'b0;
    end else if (!halted) begin
      // ebreak keeps its own pc so the core parks on it
      if (!ebreak) pc <= {target[31:1], 1'b0}; // bit 0 only matters for jalr
      halted <= ebreak;
    end
  end

  pcAligned: assert property (
    @(posedge clk) disable iff (rst) pc[1:0] == 2'b00
  ) else $error("pc %h is not word aligned", pc);

endmodule

// File: hw/rvLsu.sv
module rvLsu (
  input  rvCorePkg::ctrlT    ctrl,
  input  logic [31:0]        addr,
  input  logic [31:0]        storeData,
  input  logic               halted,
  input  logic [31:0]        dmemRdata,
  output rvCorePkg::dmemReqT dmemReq,
  output logic [31:0]        loadData
);
  import rvCorePkg::*;

  logic [1:0]  offset;
  logic [3:0]  sizeMask;
  logic [7:0]  loadByte;
  logic [15:0] loadHalf;

  assign offset = addr[1:0];

  ////////////////////////////////////////////////////////////
  // store side
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (ctrl.memFunct3[1:0])
      2'b00:   sizeMask = 4'b0001;
      2'b01:   sizeMask = 4'b0011;
      default: sizeMask = 4'b1111;
    endcase

    dmemReq.addr = addr;
    // replicate so the selected lane carries the data whatever the offset
    case (ctrl.memFunct3[1:0])
      2'b00:   dmemReq.wdata = {4{storeData[7:0]}};
      2'b01:   dmemReq.wdata = {2{storeData[15:0]}};
      default: dmemReq.wdata = storeData;
    endcase

    if (ctrl.memWrite && !halted) dmemReq.wstrb = sizeMask << offset;
    else dmemReq.wstrb = 4'b0000;
    dmemReq.read = ctrl.memRead && !halted;

    assert (dmemReq.wstrb == 4'b0000 || ctrl.memWrite)
      else $error("byte strobes %b raised without a store", dmemReq.wstrb);
  end

  ////////////////////////////////////////////////////////////
  // load side
  ////////////////////////////////////////////////////////////
  assign loadByte = dmemRdata[{offset, 3'b000} +: 8];
  assign loadHalf = offset[1] ? dmemRdata[31:16] : dmemRdata[15:0];

  always_comb begin
    case (ctrl.memFunct3)
      3'b000:  loadData = {{24{loadByte[7]}}, loadByte};  // lb
      3'b001:  loadData = {{16{loadHalf[15]}}, loadHalf}; // lh
      3'b100:  loadData = {24'b0, loadByte};              // lbu
      3'b101:  loadData = {16'b0, loadHalf};              // lhu
      default: loadData = dmemRdata;                      // lw and anything unused
    endcase
  end

endmodule

// File: hw/rvRegFile.sv
module rvRegFile (
  input  logic        clk,
  input  logic        rst,
  input  logic        we,
  input  logic [4:0]  waddr,
  input  logic [31:0] wdata,
  input  logic [4:0]  raddr1,
  input  logic [4:0]  raddr2,
  output logic [31:0] rdata1,
  output logic [31:0] rdata2
);

  logic [31:0] regs [32];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != 5'd0) begin // x0 is never stored to
      regs[waddr] <= wdata;
    end
  end

  // reads are combinational so the same cycle sees the operands
  assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
  assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

  // a write aimed at x0 must not leave anything behind for the next read
  x0StaysZero: assert property (
    @(posedge clk) disable iff (rst)
    (we && waddr == 5'd0) |=> (regs[0] == 32'd0 && (raddr1 != 5'd0 || rdata1 == 32'd0))
  ) else $error("x0 changed after a write to it");

endmodule

// File: rvCore.f
+incdir+tests
hw/rvCorePkg.sv
hw/rvDecoder.sv
hw/rvRegFile.sv
hw/rvAlu.sv
hw/rvLsu.sv
hw/rvFetch.sv
hw/rvCore.sv
tests/rvCoreTb.sv

// File: tests/rvCoreCases.svh
`ifndef rvCoreCasesSvh
`define rvCoreCasesSvh

////////////////////////////////////////////////////////////
// instruction encoders taking field values as plain ints
////////////////////////////////////////////////////////////
function automatic logic [31:0] encR(input int f7, input int rs2, input int rs1, input int f3,
                                     input int rd, input logic [6:0] op);
  return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op};
endfunction

function automatic logic [31:0] encI(input int imm, input int rs1, input int f3, input int rd,
                                     input logic [6:0] op);
  return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
endfunction

function automatic logic [31:0] encS(input int imm, input int rs2, input int rs1, input int f3);
  return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], opStore};
endfunction

function automatic logic [31:0] encB(input int imm, input int rs2, input int rs1, input int f3);
  return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], opBranch};
endfunction

function automatic logic [31:0] encU(input int imm, input int rd, input logic [6:0] op);
  return {imm[19:0], rd[4:0], op};
endfunction

function automatic logic [31:0] encJ(input int imm, input int rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], opJal};
endfunction

// expected values follow the RV32I rules given x1 = 5, x2 = -3 and x13 = 0x10100
task automatic buildCases();
  logic [31:0] w40;
  logic [31:0] w41;
  logic [31:0] w42;
  logic [31:0] w43;
  logic [31:0] link;
  w40 = dmem[8'h40];
  w41 = dmem[8'h41];
  w42 = dmem[8'h42];
  w43 = dmem[8'h43];
  modelPc = resetVector;
  parked  = 1'b0;

  writeCase(encI(5, 0, 0, 1, opAluImm), 1, 32'd5);
  writeCase(encI(-3, 0, 0, 2, opAluImm), 2, 32'hffff_fffd);
  writeCase(encR(7'h00, 2, 1, 0, 3, opAluReg), 3, 32'd2);
  writeCase(encR(7'h20, 2, 1, 0, 4, opAluReg), 4, 32'd8);
  writeCase(encU(20'h12345, 5, opLui), 5, 32'h1234_5000);
  writeCase(encU(1, 6, opAuipc), 6, modelPc + 32'h1000);
  writeCase(encI(4, 2, 1, 7, opAluImm), 7, 32'hffff_ffd0);        // slli
  writeCase(encI(28, 2, 5, 8, opAluImm), 8, 32'h0000_000f);       // srli
  writeCase(encI(32'h401, 2, 5, 9, opAluImm), 9, 32'hffff_fffe);  // srai by one
  writeCase(encR(7'h00, 1, 1, 1, 10, opAluReg), 10, 32'h0000_00a0);
  writeCase(encR(7'h00, 1, 2, 2, 11, opAluReg), 11, 32'd1);       // slt sees -3 < 5
  writeCase(encR(7'h00, 1, 2, 3, 12, opAluReg), 12, 32'd0);       // sltu sees a huge rs1
  addCase(encI(7, 1, 0, 0, opAluImm), 1'b0, 0, 32'd0, 4'b0000, modelPc + 4);

  ////////////////////////////////////////////////////////////
  // loads and stores around 0x10100
  ////////////////////////////////////////////////////////////
  writeCase(encU(32'h10, 13, opLui), 13, 32'h0001_0000);
  writeCase(encI(32'h100, 13, 0, 13, opAluImm), 13, 32'h0001_0100);
  writeCase(encI(0, 13, 2, 14, opLoad), 14, w40);
  writeCase(encI(5, 13, 0, 15, opLoad), 15, {{24{w41[15]}}, w41[15:8]});
  writeCase(encI(7, 13, 4, 16, opLoad), 16, {24'd0, w41[31:24]});
  writeCase(encI(10, 13, 1, 17, opLoad), 17, {{16{w42[31]}}, w42[31:16]});
  writeCase(encI(12, 13, 5, 18, opLoad), 18, {16'd0, w43[15:0]});
  storeCase(encS(-4, 2, 13, 2), 4'b1111);
  writeCase(encI(-4, 13, 2, 19, opLoad), 19, 32'hffff_fffd);
  storeCase(encS(1, 1, 13, 0), 4'b0010);
  storeCase(encS(2, 2, 13, 1), 4'b1100);
  keptWord = {16'hfffd, 8'h05, w40[7:0]};
  writeCase(encI(0, 13, 2, 20, opLoad), 20, keptWord);

  ////////////////////////////////////////////////////////////
  // branches, jumps and halt
  ////////////////////////////////////////////////////////////
  flowCase(encB(8, 1, 1, 0), modelPc + 8);    // beq taken
  flowCase(encB(8, 1, 1, 1), modelPc + 4);    // bne not taken
  flowCase(encB(12, 1, 2, 4), modelPc + 12);  // blt taken
  flowCase(encB(-16, 1, 2, 7), modelPc - 16); // bgeu taken backwards
  flowCase(encB(8, 1, 2, 6), modelPc + 4);    // bltu not taken
  flowCase(encB(16, 2, 1, 5), modelPc + 16);  // bge taken
  addCase(encJ(-20, 21), 1'b1, 21, modelPc + 4, 4'b0000, modelPc - 20);
  link = modelPc;
  writeCase(encU(0, 23, opAuipc), 23, link);
  addCase(encI(13, 23, 0, 22, opJalr), 1'b1, 22, modelPc + 4, 4'b0000,
          (link + 32'd13) & ~32'd1);
  flowCase(encJ(8, 0), modelPc + 8);
  flowCase(ebreakWord, modelPc);
  flowCase(encI(1, 0, 0, 24, opAluImm), modelPc);
  flowCase(encS(0, 1, 13, 2), modelPc);        // no strobes once halted
  flowCase(encI(0, 13, 2, 25, opLoad), modelPc); // no read once halted
endtask

`endif

// File: tests/rvCoreTb.sv
module rvCoreTb;
  timeunit 1ns;
  timeprecision 1ps;
  import rvCorePkg::*;

  localparam logic [31:0] nopWord = 32'h0000_0013;
  localparam logic [31:0] lcgSeed = 32'h97b3_7b15;

  typedef struct packed {
    logic [31:0] inst;
    logic        valid;
    logic [4:0]  rd;
    logic [31:0] data;
    logic [3:0]  wstrb;
    logic        read;
    logic [31:0] nextPc;
  } caseT;

  logic        clk;
  logic        rst;
  logic [31:0] inst;
  logic [31:0] dmemRdata;
  logic [31:0] instAddr;
  dmemReqT     dmemReq;
  commitT      commit;
  logic        halted;

  logic [31:0] dmem [256];
  caseT        cases [$];
  logic [31:0] modelPc;
  logic        parked;
  logic [31:0] keptWord;
  int          errorCount;

  rvCore dut_i (.clk, .rst, .inst, .dmemRdata, .instAddr, .dmemReq, .commit, .halted);

  assign dmemRdata = dmem[dmemReq.addr[9:2]]; // word index wraps every 1 KiB

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] lcgNext(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic fillMemory();
    logic [31:0] state;
    state = lcgSeed;
    for (int i = 0; i < 256; i++) begin
      state = lcgNext(state);
      dmem[i] = state;
    end
  endtask

  task automatic addCase(input logic [31:0] word, input logic valid, input int rd,
                         input logic [31:0] data, input logic [3:0] wstrb,
                         input logic [31:0] nextPc);
    caseT c;
    c.inst   = word;
    c.valid  = valid;
    c.rd     = rd[4:0];
    c.data   = data;
    c.wstrb  = wstrb;
    c.read   = (word[6:0] == opLoad) && !parked; // a parked core issues no reads
    c.nextPc = nextPc;
    cases.push_back(c);
    modelPc = nextPc;
    if (word == ebreakWord) parked = 1'b1;
  endtask

  task automatic writeCase(input logic [31:0] word, input int rd, input logic [31:0] data);
    addCase(word, 1'b1, rd, data, 4'b0000, modelPc + 4);
  endtask

  task automatic storeCase(input logic [31:0] word, input logic [3:0] wstrb);
    addCase(word, 1'b0, 0, 32'd0, wstrb, modelPc + 4);
  endtask

  task automatic flowCase(input logic [31:0] word, input logic [31:0] nextPc);
    addCase(word, 1'b0, 0, 32'd0, 4'b0000, nextPc);
  endtask

  `include "rvCoreCases.svh"

  task automatic checkField(input string name, input logic [31:0] got, input logic [31:0] want);
    assert (got === want) else begin
      $display("MISMATCH %s: got %h expected %h", name, got, want);
      errorCount++;
    end
  endtask

  task automatic checkCase(input caseT c, input logic [31:0] expPc);
    checkField("commit.valid", 32'(commit.valid), 32'(c.valid));
    if (c.valid) begin
      checkField("commit.rd", 32'(commit.rd), 32'(c.rd));
      checkField("commit.data", commit.data, c.data);
    end
    checkField("commit.pc", commit.pc, expPc);
    checkField("instAddr", instAddr, expPc);
    checkField("dmemReq.wstrb", 32'(dmemReq.wstrb), 32'(c.wstrb));
    checkField("dmemReq.read", 32'(dmemReq.read), 32'(c.read));
  endtask

  // the request is sampled before the edge and lands in memory right after it
  task automatic storeWord(input dmemReqT req);
    for (int b = 0; b < 4; b++) begin
      if (req.wstrb[b]) dmem[req.addr[9:2]][8*b +: 8] = req.wdata[8*b +: 8];
    end
  endtask

  initial begin
    caseT        c;
    dmemReqT     req;
    logic [31:0] expPc;
    int          errBefore;
    int          passedCases;
    int          waitCycles;
    logic        timedOut;
    rst         = 1'b1;
    inst        = nopWord;
    errorCount  = 0;
    passedCases = 0;
    fillMemory();
    buildCases();
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst   = 1'b0;
    expPc = resetVector;

    for (int n = 0; n < cases.size(); n++) begin
      c         = cases[n];
      errBefore = errorCount;
      inst      = c.inst;
      #2;
      checkCase(c, expPc);
      req = dmemReq;
      @(posedge clk);
      #1;
      storeWord(req);
      checkField("next instAddr", instAddr, c.nextPc);
      if (errorCount == errBefore) passedCases++;
      $display("case %2d  pc %h  inst %h  %s", n, expPc, c.inst,
               (errorCount == errBefore) ? "ok" : "error");
      expPc = c.nextPc;
      @(negedge clk);
    end

    waitCycles = 0;
    while (!halted && waitCycles < 20) begin
      @(posedge clk);
      #1;
      waitCycles++;
    end
    timedOut = !halted;
    if (timedOut) $display("timeout: halted did not rise within 20 cycles after ebreak");
    checkField("dmem[0x40]", dmem[8'h40], keptWord); // the store after ebreak must not land

    $display("%0d cases, %0d passed, %0d failed, %0d check errors", cases.size(), passedCases,
             cases.size() - passedCases, errorCount);
    if (errorCount == 0 && !timedOut) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
